//--- rtl/scan_geom_pkg.sv
/*
  scan geometry
  line, window and frame sizes of the binary window scanner,
  all counted in pixels, beats (pixel pairs) or lines
*/

package scan_geom_pkg;

  // ******************************
  // pixel stream
  // ******************************
  localparam int PIX_PER_BEAT = 2;
  localparam int LINE_PIX     = 32;
  localparam int LINE_PAIRS   = LINE_PIX / PIX_PER_BEAT;

  // ******************************
  // window and line delay
  // ******************************
  localparam int WIN        = 8;
  localparam int WIN_PAIRS  = WIN / PIX_PER_BEAT;
  // beats a pair spends outside the window rows per line
  localparam int LINE_DELAY = LINE_PAIRS - WIN_PAIRS;

  // frame height and counter widths
  localparam int FRAME_LINES = 12;
  localparam int COL_W       = 4;
  localparam int LINE_W      = 4;

endpackage

//--- rtl/window_pkg.sv
/*
  window types
  pixel pair, window row and window vectors, the scan position
  struct and the scan FSM states
*/

package window_pkg;

  // bit 0 is the left pixel of the beat
  typedef logic [scan_geom_pkg::PIX_PER_BEAT-1:0] pix_pair_t;

  // bit 0 is the leftmost pixel
  typedef logic [scan_geom_pkg::WIN-1:0] win_row_t;

  // row 0 is the oldest (top) line
  typedef win_row_t [scan_geom_pkg::WIN-1:0] win_rows_t;

  // column-major, pixel (r, x) at bit x*WIN + r
  typedef logic [scan_geom_pkg::WIN*scan_geom_pkg::WIN-1:0] window_t;

  typedef logic [scan_geom_pkg::COL_W-1:0]  col_t;
  typedef logic [scan_geom_pkg::LINE_W-1:0] line_t;

  typedef struct packed {
    col_t  col;
    line_t line;
  } scan_pos_t;

  typedef enum logic [1:0] {
    IDLE,
    FILL,
    ACTIVE,
    GAP
  } scan_state_t;

endpackage

//--- rtl/scan_counter.sv
/*
  scan position counter
  tracks the beat column and line of the pair now presented;
  advances on valid beats and returns to the frame origin
  when the FSM flags the last beat of the frame
*/

`timescale 1ns/1ps

module scan_counter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  pix_valid,
  input  logic                  frame_end,
  output window_pkg::scan_pos_t pos
);

  logic col_last;

  // last beat of a line
  assign col_last = (pos.col == window_pkg::col_t'(scan_geom_pkg::LINE_PAIRS - 1));

  // ******************************
  // column and line count
  // ******************************
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pos <= '0;
    end
    else if (frame_end)
    begin
      // frame wrap wins over the line wrap
      pos <= '0;
    end
    else if (pix_valid)
    begin
      if (col_last)
      begin
        pos.col  <= '0;
        pos.line <= pos.line + 1'b1;
      end
      else
      begin
        pos.col <= pos.col + 1'b1;
      end
    end
  end

endmodule

//--- rtl/scan_fsm.sv
/*
  scan FSM
  follows the frame through fill, active and gap phases and
  registers the window-complete strobe for each valid beat;
  flags the last beat of the frame to the position counter
*/

`timescale 1ns/1ps

module scan_fsm (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  pix_valid,
  input  window_pkg::scan_pos_t pos,
  output logic                  win_strobe,
  output logic                  frame_end
);

  window_pkg::scan_state_t state;
  window_pkg::scan_state_t state_next;
  logic                    complete;
  logic                    line_end;
  logic                    gap_done;

  // beat whose window lies wholly inside the frame
  assign complete = (pos.line >= window_pkg::line_t'(scan_geom_pkg::WIN - 1)) &&
                    (pos.col >= window_pkg::col_t'(scan_geom_pkg::WIN_PAIRS - 1));
  assign line_end = (pos.col == window_pkg::col_t'(scan_geom_pkg::LINE_PAIRS - 1));
  // last beat before the window fits again on the new line
  assign gap_done = (pos.col == window_pkg::col_t'(scan_geom_pkg::WIN_PAIRS - 2));

  assign frame_end = pix_valid && line_end &&
                     (pos.line == window_pkg::line_t'(scan_geom_pkg::FRAME_LINES - 1));

  // ******************************
  // state transitions
  // ******************************
  always_comb
  begin
    state_next = state;
    if (pix_valid)
    begin
      case (state)
        window_pkg::IDLE:   state_next = window_pkg::FILL;
        window_pkg::FILL:   if (complete) state_next = window_pkg::ACTIVE;
        window_pkg::ACTIVE: if (line_end) state_next = window_pkg::GAP;
        window_pkg::GAP:    if (gap_done) state_next = window_pkg::ACTIVE;
        default:            state_next = window_pkg::IDLE;
      endcase
      if (frame_end)
        state_next = window_pkg::IDLE;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= window_pkg::IDLE;
      win_strobe <= 1'b0;
    end
    else
    begin
      state <= state_next;
      // gap and idle beats never complete a window
      win_strobe <= pix_valid && complete &&
                    ((state == window_pkg::FILL) || (state == window_pkg::ACTIVE));
    end
  end

endmodule

//--- rtl/line_window.sv
/*
  window line buffer
  WIN row shift registers, newest line in the last row; the pair
  leaving each row's left end runs through a line delay memory
  and enters the row above, so row 0 holds the oldest line
*/

`timescale 1ns/1ps

module line_window (
  input  logic                  clk,
  input  logic                  rst,
  input  window_pkg::pix_pair_t pix_in,
  input  logic                  pix_valid,
  output window_pkg::win_rows_t rows
);

  // one delay line per row that feeds a row above it
  window_pkg::pix_pair_t dly_mem [1:scan_geom_pkg::WIN-1][scan_geom_pkg::LINE_DELAY];
  logic [$clog2(scan_geom_pkg::LINE_DELAY)-1:0] dly_ptr;
  window_pkg::pix_pair_t dly_out [0:scan_geom_pkg::WIN-2];

  // ******************************
  // line delays
  // ******************************
  // read before write at a shared pointer gives exactly LINE_DELAY beats
  always_comb
  begin
    for (int k = 0; k < scan_geom_pkg::WIN - 1; k++)
      dly_out[k] = dly_mem[k+1][dly_ptr];
  end

  always_ff @(posedge clk)
  begin
    if (pix_valid)
    begin
      for (int k = 1; k < scan_geom_pkg::WIN; k++)
        dly_mem[k][dly_ptr] <= rows[k][scan_geom_pkg::PIX_PER_BEAT-1:0];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      dly_ptr <= '0;
    end
    else if (pix_valid)
    begin
      if (dly_ptr == ($clog2(scan_geom_pkg::LINE_DELAY))'(scan_geom_pkg::LINE_DELAY - 1))
        dly_ptr <= '0;
      else
        dly_ptr <= dly_ptr + 1'b1;
    end
  end

  // ******************************
  // window rows
  // ******************************
  // pairs enter at the right end and move toward bit 0
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rows <= '0;
    end
    else if (pix_valid)
    begin
      rows[scan_geom_pkg::WIN-1] <= {pix_in,
        rows[scan_geom_pkg::WIN-1][scan_geom_pkg::WIN-1:scan_geom_pkg::PIX_PER_BEAT]};
      for (int k = 0; k < scan_geom_pkg::WIN - 1; k++)
      begin
        rows[k] <= {dly_out[k],
          rows[k][scan_geom_pkg::WIN-1:scan_geom_pkg::PIX_PER_BEAT]};
      end
    end
  end

endmodule

//--- rtl/window_transpose.sv
/*
  window output stage
  reorders the row-major window into column-major order and
  registers it together with its valid strobe
*/

`timescale 1ns/1ps

module window_transpose (
  input  logic                  clk,
  input  logic                  rst,
  input  window_pkg::win_rows_t rows,
  input  logic                  win_strobe,
  output window_pkg::window_t   window_data,
  output logic                  window_valid
);

  window_pkg::window_t col_major;

  // pixel (r, x) lands at bit x*WIN + r
  always_comb
  begin
    for (int r = 0; r < scan_geom_pkg::WIN; r++)
      for (int x = 0; x < scan_geom_pkg::WIN; x++)
        col_major[x*scan_geom_pkg::WIN + r] = rows[r][x];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      window_data  <= '0;
      window_valid <= 1'b0;
    end
    else
    begin
      window_valid <= win_strobe;
      // hold the last window between strobes
      if (win_strobe)
        window_data <= col_major;
    end
  end

endmodule

//--- rtl/window_scan_top.sv
/*
  window scanner top
  sliding WIN x WIN window over a two-pixel-per-beat binary
  image stream; emits each window lying wholly inside the frame
*/

`timescale 1ns/1ps

module window_scan_top (
  input  logic                  clk,
  input  logic                  rst,
  input  window_pkg::pix_pair_t pix_in,
  input  logic                  pix_valid,
  output window_pkg::window_t   window_data,
  output logic                  window_valid
);

  window_pkg::scan_pos_t pos;
  window_pkg::win_rows_t rows;
  logic                  frame_end;
  logic                  win_strobe;

  // ******************************
  // scan control
  // ******************************
  scan_counter u_scan_counter (
    .clk       (clk),
    .rst       (rst),
    .pix_valid (pix_valid),
    .frame_end (frame_end),
    .pos       (pos)
  );

  scan_fsm u_scan_fsm (
    .clk        (clk),
    .rst        (rst),
    .pix_valid  (pix_valid),
    .pos        (pos),
    .win_strobe (win_strobe),
    .frame_end  (frame_end)
  );

  // data path
  line_window u_line_window (
    .clk       (clk),
    .rst       (rst),
    .pix_in    (pix_in),
    .pix_valid (pix_valid),
    .rows      (rows)
  );

  window_transpose u_window_transpose (
    .clk          (clk),
    .rst          (rst),
    .rows         (rows),
    .win_strobe   (win_strobe),
    .window_data  (window_data),
    .window_valid (window_valid)
  );

endmodule

//--- test/tb_checks.svh
/*
  testbench checks
  LCG pixel source, error and test counters and the compare
  tasks for windows and window counts
*/

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int unsigned lcg_state = 63;
int          err_count = 0;
int          pass_tests = 0;
int          fail_tests = 0;

// ******************************
// random numbers
// ******************************
function automatic int unsigned lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// ******************************
// compare tasks
// ******************************
task automatic check_window(input string name, input window_pkg::window_t got,
                            input window_pkg::window_t exp);
  if (got !== exp)
  begin
    err_count++;
    $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
  end
endtask

task automatic check_count(input string name, input int got, input int exp);
  if (got != exp)
  begin
    err_count++;
    $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
  end
endtask

`endif

//--- test/tb_window_scan.sv
/*
  window scanner testbench
  streams random and patterned frames into the scanner, keeps a
  reference image and checks every emitted window against it
*/

`timescale 1ns/1ps

module tb_window_scan;

  localparam int FRAME_BEATS = scan_geom_pkg::FRAME_LINES * scan_geom_pkg::LINE_PAIRS;
  localparam int WINS_PER_FRAME =
    (scan_geom_pkg::FRAME_LINES - scan_geom_pkg::WIN + 1) *
    (scan_geom_pkg::LINE_PAIRS - scan_geom_pkg::WIN_PAIRS + 1);
  // 30 idle cycles plus five streamed frames
  localparam int CYCLE_LIMIT = 2 * (30 + 5 * FRAME_BEATS) + 200;
  // cycles from driving the completing beat to its window_valid
  localparam int OUT_LATENCY = 2;

  logic                  clk;
  logic                  rst;
  window_pkg::pix_pair_t pix_in;
  logic                  pix_valid;
  window_pkg::window_t   window_data;
  logic                  window_valid;

  // reference image, one bit per pixel
  bit img [0:scan_geom_pkg::FRAME_LINES-1][0:scan_geom_pkg::LINE_PIX-1];
  window_pkg::window_t exp_q[$];
  // cycle at which each completing beat was driven
  int beat_cycle_q[$];
  int seen_windows = 0;
  int cycles = 0;

  `include "tb_checks.svh"

  window_scan_top dut (
    .clk          (clk),
    .rst          (rst),
    .pix_in       (pix_in),
    .pix_valid    (pix_valid),
    .window_data  (window_data),
    .window_valid (window_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped: no result within %0d cycles", CYCLE_LIMIT);
    $display("Simulation FAILED");
    $finish;
  end

  // ******************************
  // output monitor
  // ******************************
  always @(negedge clk)
  begin
    if (!rst && window_valid)
    begin
      seen_windows++;
      if (exp_q.size() == 0 || beat_cycle_q.size() == 0)
      begin
        err_count++;
        $display("window_valid pulsed while no window was expected");
      end
      else
      begin
        check_window("window_data", window_data, exp_q.pop_front());
        check_count("window latency", cycles - beat_cycle_q.pop_front(), OUT_LATENCY);
      end
    end
  end

  // ******************************
  // reference model
  // ******************************
  // window completed at beat (line, col), column-major bit x*WIN + r
  function automatic window_pkg::window_t expected_window(input int line, input int col);
    window_pkg::window_t w;
    int top;
    int left;
    w = '0;
    top = line - (scan_geom_pkg::WIN - 1);
    left = (col - (scan_geom_pkg::WIN_PAIRS - 1)) * scan_geom_pkg::PIX_PER_BEAT;
    for (int r = 0; r < scan_geom_pkg::WIN; r++)
      for (int x = 0; x < scan_geom_pkg::WIN; x++)
        w[x*scan_geom_pkg::WIN + r] = img[top+r][left+x];
    return w;
  endfunction

  // raster order of the completing beats
  task automatic queue_windows();
    for (int y = scan_geom_pkg::WIN - 1; y < scan_geom_pkg::FRAME_LINES; y++)
      for (int c = scan_geom_pkg::WIN_PAIRS - 1; c < scan_geom_pkg::LINE_PAIRS; c++)
        exp_q.push_back(expected_window(y, c));
  endtask

  task automatic fill_random();
    for (int y = 0; y < scan_geom_pkg::FRAME_LINES; y++)
      for (int x = 0; x < scan_geom_pkg::LINE_PIX; x++)
        img[y][x] = ((lcg_next() >> 16) & 1) != 0;
  endtask

  // column parity xor a line bit picked by the column
  task automatic fill_pattern();
    for (int y = 0; y < scan_geom_pkg::FRAME_LINES; y++)
      for (int x = 0; x < scan_geom_pkg::LINE_PIX; x++)
        img[y][x] = ((x & 1) ^ ((y >> (x % 4)) & 1)) != 0;
  endtask

  // ******************************
  // stimulus
  // ******************************
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic stream_frame(input bit with_gaps);
    for (int y = 0; y < scan_geom_pkg::FRAME_LINES; y++)
    begin
      for (int c = 0; c < scan_geom_pkg::LINE_PAIRS; c++)
      begin
        while (with_gaps && (((lcg_next() >> 20) & 3) == 0))
        begin
          pix_valid = 1'b0;
          step();
        end
        pix_in = {img[y][2*c+1], img[y][2*c]};
        pix_valid = 1'b1;
        // beat whose window lies wholly inside the frame
        if (y >= scan_geom_pkg::WIN - 1 && c >= scan_geom_pkg::WIN_PAIRS - 1)
          beat_cycle_q.push_back(cycles);
        step();
      end
    end
    pix_valid = 1'b0;
  endtask

  task automatic end_test(input string name, input int exp_count, input int errs_before);
    int waited;
    waited = 0;
    while (exp_q.size() > 0 && waited < 20)
    begin
      step();
      waited++;
    end
    // a few idle cycles catch any extra strobe
    repeat (4) step();
    check_count("window count", seen_windows, exp_count);
    exp_q.delete();
    beat_cycle_q.delete();
    if (err_count == errs_before)
    begin
      pass_tests++;
      $display("test %s passed", name);
    end
    else
    begin
      fail_tests++;
      $display("test %s failed with %0d errors", name, err_count - errs_before);
    end
  endtask

  // ******************************
  // directed tests
  // ******************************
  task automatic test_reset_silence();
    int errs;
    errs = err_count;
    seen_windows = 0;
    pix_valid = 1'b0;
    repeat (30) step();
    end_test("reset_silence", 0, errs);
  endtask

  task automatic test_frame(input string name, input bit pattern, input bit with_gaps);
    int errs;
    errs = err_count;
    seen_windows = 0;
    if (pattern)
      fill_pattern();
    else
      fill_random();
    queue_windows();
    stream_frame(with_gaps);
    end_test(name, WINS_PER_FRAME, errs);
  endtask

  task automatic test_back_to_back();
    int errs;
    errs = err_count;
    seen_windows = 0;
    for (int f = 0; f < 2; f++)
    begin
      fill_random();
      queue_windows();
      stream_frame(1'b0);
    end
    end_test("back_to_back", 2 * WINS_PER_FRAME, errs);
  endtask

  initial
  begin
    rst = 1'b1;
    pix_valid = 1'b0;
    pix_in = '0;
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    test_reset_silence();
    test_frame("full_frame", 1'b0, 1'b0);
    test_frame("orientation", 1'b1, 1'b0);
    test_frame("gaps", 1'b0, 1'b1);
    test_back_to_back();
    $display("tests passed: %0d  failed: %0d", pass_tests, fail_tests);
    if (fail_tests == 0 && err_count == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- tb.f
+incdir+test
rtl/scan_geom_pkg.sv
rtl/window_pkg.sv
rtl/scan_counter.sv
rtl/scan_fsm.sv
rtl/line_window.sv
rtl/window_transpose.sv
rtl/window_scan_top.sv
test/tb_window_scan.sv

//--- Bender.yml
package:
  name: window_scan

sources:
  - rtl/scan_geom_pkg.sv
  - rtl/window_pkg.sv
  - rtl/scan_counter.sv
  - rtl/scan_fsm.sv
  - rtl/line_window.sv
  - rtl/window_transpose.sv
  - rtl/window_scan_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_window_scan.sv
